// ==== all.f ====
+incdir+include
source/apb_pkg.sv
source/uart_pkg.sv
source/apb_if.sv
source/apb_decode_mux.sv
source/uart_tx_unit.sv
source/uart_rx_unit.sv
source/periph_top.sv
verif/tb_periph.sv

// ==== Bender.yml ====
package:
  name: periph_subsys

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/apb_pkg.sv
      - source/uart_pkg.sv
      - source/apb_if.sv
      - source/apb_decode_mux.sv
      - source/uart_tx_unit.sv
      - source/uart_rx_unit.sv
      - source/periph_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_periph.sv

// ==== verif/tb_periph.sv ====
`include "periph_cfg.svh"

module tb_periph;

	// Generous bound, 20 frames at twice their nominal length
	localparam int CYCLE_LIMIT = 20 * 10 * `PERIPH_CLKDIV * 2;

	localparam logic [`PERIPH_ADDR_W-1:0] TX_DATA_ADDR = `PERIPH_TX_BASE + 12'h0;
	localparam logic [`PERIPH_ADDR_W-1:0] TX_STAT_ADDR = `PERIPH_TX_BASE + 12'h4;
	localparam logic [`PERIPH_ADDR_W-1:0] RX_DATA_ADDR = `PERIPH_RX_BASE + 12'h0;
	localparam logic [`PERIPH_ADDR_W-1:0] RX_STAT_ADDR = `PERIPH_RX_BASE + 12'h4;
	localparam logic [`PERIPH_ADDR_W-1:0] HOLE_ADDR    = 12'h200;

	logic                      clk;
	logic                      arst_n;
	logic                      psel;
	logic                      penable;
	logic                      pwrite;
	logic [`PERIPH_ADDR_W-1:0] paddr;
	logic [`PERIPH_DATA_W-1:0] pwdata;
	logic [`PERIPH_DATA_W-1:0] prdata;
	logic                      pready;
	logic                      pslverr;
	logic                      tx;
	logic                      irq;

	// Expected response of the transfer on the bus
	logic [`PERIPH_DATA_W-1:0] exp_data;
	logic [`PERIPH_DATA_W-1:0] exp_mask;
	logic                      exp_err;

	// Receiver model state
	int                        held_cnt;
	int                        ovf_cnt;
	logic [7:0]                sent_q[$];

	logic [31:0]               lcg_state;
	int                        cycles;
	int                        fail_cnt;

	// ------------------------------
	// DUT, tx looped back into rx

	periph_top dut0 (
		.clk     (clk),
		.arst_n  (arst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.rx      (tx),
		.tx      (tx),
		.irq     (irq)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Hang guard
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Test hung: cycle limit reached before all tests finished");
			$display("Verification failed");
			$fatal(1);
		end
	end

	// ------------------------------
	// Helpers

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Status as {overrun, valid} from arrivals since the last
	// data read and overflows since the last status read
	function automatic logic [31:0] ref_rx_status(input int held, input int ovf);
		return {30'b0, (ovf > 0), (held > 0)};
	endfunction

	task automatic show_error(input string msg);
		fail_cnt++;
		$display("error at time %0t: %s", $time, msg);
		$display("Verification failed");
	endtask

	// Compare process, sampled mid cycle where the response is settled
	always @(negedge clk) begin
		// Zero wait states, and no completion outside an access cycle
		assert (pready == (psel && penable)) else begin
			show_error($sformatf("pready is %0b with psel %0b penable %0b",
				pready, psel, penable));
			$fatal(1);
		end
		if (psel && penable && pready) begin
			if (!pwrite) begin
				assert ((prdata & exp_mask) == (exp_data & exp_mask)) else begin
					show_error($sformatf("read of 0x%03h returned 0x%08h, expected 0x%08h",
						paddr, prdata, exp_data));
					$fatal(1);
				end
			end
			assert (pslverr == exp_err) else begin
				show_error($sformatf("access to 0x%03h gave pslverr %0b, expected %0b",
					paddr, pslverr, exp_err));
				$fatal(1);
			end
		end
	end

	// One APB transfer, setup then access until pready
	task automatic apb_access(input logic wr, input logic [`PERIPH_ADDR_W-1:0] addr,
		input logic [31:0] wdata, input logic [31:0] data, input logic [31:0] mask,
		input logic err, output logic [31:0] rdata);
		@(posedge clk);
		#5;
		exp_data = data;
		exp_mask = mask;
		exp_err  = err;
		psel     = 1'b1;
		penable  = 1'b0;
		pwrite   = wr;
		paddr    = addr;
		pwdata   = wdata;
		@(posedge clk);
		#5;
		penable = 1'b1;
		@(negedge clk);
		while (!pready)
			@(negedge clk);
		rdata = prdata;
		@(posedge clk);
		#5;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic send_byte(input logic [7:0] b);
		logic [31:0] unused;
		apb_access(1'b1, TX_DATA_ADDR, {24'b0, b}, '0, '0, 1'b0, unused);
		sent_q.push_back(b);
	endtask

	// Byte has landed in rx, overflow if one was still held
	task automatic note_arrival();
		if (held_cnt > 0)
			ovf_cnt++;
		held_cnt++;
	endtask

	task automatic wait_irq();
		while (!irq)
			@(negedge clk);
	endtask

	// Poll tx busy, only bit 0 may be set
	task automatic wait_tx_idle();
		logic [31:0] st;
		do
			apb_access(1'b0, TX_STAT_ADDR, '0, '0, 32'hffff_fffe, 1'b0, st);
		while (st[0]);
	endtask

	task automatic read_rx_data();
		logic [31:0] unused;
		if (held_cnt > 0) begin
			apb_access(1'b0, RX_DATA_ADDR, '0, {24'b0, sent_q[0]}, '1, 1'b0, unused);
			// Later bytes were overwritten or dropped
			sent_q.delete();
			held_cnt = 0;
		end else begin
			apb_access(1'b0, RX_DATA_ADDR, '0, '0, '0, 1'b1, unused);
		end
		@(negedge clk);
		assert (irq == (held_cnt > 0)) else begin
			show_error($sformatf("irq is %0b after data read", irq));
			$fatal(1);
		end
	endtask

	task automatic read_rx_status();
		logic [31:0] unused;
		apb_access(1'b0, RX_STAT_ADDR, '0, ref_rx_status(held_cnt, ovf_cnt), '1, 1'b0,
			unused);
		ovf_cnt = 0;
	endtask

	// ------------------------------
	// Test sequence

	initial begin
		logic [31:0] rd;
		logic [7:0]  b;

		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = '0;
		pwdata    = '0;
		exp_data  = '0;
		exp_mask  = '0;
		exp_err   = 1'b0;
		held_cnt  = 0;
		ovf_cnt   = 0;
		cycles    = 0;
		fail_cnt  = 0;
		lcg_state = 32'hb676;
		arst_n    = 1'b0;
		repeat (2) @(posedge clk);
		#5;
		arst_n = 1'b1;

		// Reset values
		@(negedge clk);
		assert (tx === 1'b1 && irq === 1'b0) else begin
			show_error($sformatf("after reset tx=%b irq=%b", tx, irq));
			$fatal(1);
		end
		apb_access(1'b0, TX_STAT_ADDR, '0, '0, '1, 1'b0, rd);
		read_rx_status();

		// Error responses, empty rx, hole in the map, read only register
		read_rx_data();
		apb_access(1'b0, HOLE_ADDR, '0, '0, '1, 1'b1, rd);
		apb_access(1'b1, HOLE_ADDR, 32'h5a, '0, '0, 1'b1, rd);
		apb_access(1'b1, RX_STAT_ADDR, 32'h3, '0, '0, 1'b1, rd);

		// Loopback of random bytes
		for (int i = 0; i < 8; i++) begin
			lcg_state = lcg_next(lcg_state);
			b         = lcg_state[23:16];
			send_byte(b);
			wait_irq();
			note_arrival();
			read_rx_data();
		end

		// Busy flag and write while busy
		lcg_state = lcg_next(lcg_state);
		b         = lcg_state[23:16];
		send_byte(b);
		apb_access(1'b0, TX_STAT_ADDR, '0, 32'h1, '1, 1'b0, rd);
		apb_access(1'b1, TX_DATA_ADDR, {24'b0, ~b}, '0, '0, 1'b1, rd);
		wait_irq();
		note_arrival();
		apb_access(1'b0, TX_STAT_ADDR, '0, '0, '1, 1'b0, rd);
		read_rx_data();

		// Overrun, two bytes with no read between
		lcg_state = lcg_next(lcg_state);
		send_byte(lcg_state[23:16]);
		wait_irq();
		note_arrival();
		lcg_state = lcg_next(lcg_state);
		send_byte(lcg_state[23:16]);
		wait_tx_idle();
		note_arrival();
		read_rx_status();
		read_rx_status();
		read_rx_data();

		if (fail_cnt == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("Verification failed");
			$fatal(1);
		end
	end

endmodule

// ==== source/periph_top.sv ====
`include "periph_cfg.svh"

module periph_top (
	// System clock and reset
	input  logic                      clk,
	input  logic                      arst_n,

	// APB completer port
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [`PERIPH_ADDR_W-1:0] paddr,
	input  logic [`PERIPH_DATA_W-1:0] pwdata,
	output logic [`PERIPH_DATA_W-1:0] prdata,
	output logic                      pready,
	output logic                      pslverr,

	// Serial lines
	input  logic                      rx,
	output logic                      tx,
	output logic                      irq
);

	// ------------------------------
	// Internal unit buses

	apb_if tx_bus ();
	apb_if rx_bus ();

	// ------------------------------
	// Address decode

	apb_decode_mux decode_u (
		.clk     (clk),
		.arst_n  (arst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.tx_bus  (tx_bus),
		.rx_bus  (rx_bus)
	);

	// ------------------------------
	// UART units, side by side

	uart_tx_unit uart_tx_u (
		.clk    (clk),
		.arst_n (arst_n),
		.bus    (tx_bus),
		.tx     (tx)
	);

	// irq follows the rx holding register
	uart_rx_unit uart_rx_u (
		.clk    (clk),
		.arst_n (arst_n),
		.bus    (rx_bus),
		.rx     (rx),
		.irq    (irq)
	);

endmodule

// ==== source/uart_rx_unit.sv ====
`include "periph_cfg.svh"

module uart_rx_unit (
	input  logic     clk,
	input  logic     arst_n,
	apb_if.completer bus,
	input  logic     rx,
	output logic     irq
);

	localparam int DIV_W = $clog2(`PERIPH_CLKDIV);

	uart_pkg::rx_state_e       state;
	uart_pkg::uart_reg_e       offset;
	apb_pkg::apb_op_e          op;
	logic                      access;
	logic                      in_page;
	logic                      err;
	logic                      data_rd;
	logic                      stat_rd;
	logic [`PERIPH_DATA_W-1:0] rdata;
	logic                      rx_meta;
	logic                      rx_sync;
	logic                      rx_prev;
	logic                      start_edge;
	logic [DIV_W-1:0]          div_cnt;
	logic                      mid_pt;
	logic                      bit_end;
	logic [2:0]                bit_idx;
	logic [7:0]                shifter;
	logic                      byte_done;
	logic [7:0]                data_q;
	logic                      valid;
	logic                      overrun;

	// ------------------------------
	// Input synchroniser

	// Two flops into the clock domain, one more for edge detect
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign start_edge = rx_prev && !rx_sync;

	// ------------------------------
	// Bit timing

	// Half a bit from the edge, then whole bits between midpoints
	assign mid_pt  = (div_cnt == DIV_W'(`PERIPH_CLKDIV / 2 - 1));
	assign bit_end = (div_cnt == DIV_W'(`PERIPH_CLKDIV - 1));

	// ------------------------------
	// Receive FSM

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= uart_pkg::RX_IDLE;
			div_cnt <= '0;
			bit_idx <= '0;
		end else begin
			case (state)
				uart_pkg::RX_IDLE: begin
					div_cnt <= '0;
					if (start_edge)
						state <= uart_pkg::RX_START;
				end
				uart_pkg::RX_START: begin
					if (mid_pt) begin
						div_cnt <= '0;
						// Glitch shorter than half a bit, back to idle
						if (!rx_sync) begin
							state   <= uart_pkg::RX_DATA;
							bit_idx <= '0;
						end else begin
							state <= uart_pkg::RX_IDLE;
						end
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				uart_pkg::RX_DATA: begin
					div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= uart_pkg::RX_STOP;
					end
				end
				default: begin
					div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
					// Back to idle at stop midpoint, ready for the next edge
					if (bit_end)
						state <= uart_pkg::RX_IDLE;
				end
			endcase
		end
	end

	// Data arrives LSB first
	always_ff @(posedge clk) begin
		if (state == uart_pkg::RX_DATA && bit_end)
			shifter <= {rx_sync, shifter[7:1]};
	end

	// Framing error drops the byte silently
	assign byte_done = (state == uart_pkg::RX_STOP) && bit_end && rx_sync;

	// ------------------------------
	// Holding register and flags

	// A read on the arrival cycle frees the slot for the new byte
	always_ff @(posedge clk) begin
		if (byte_done && (!valid || data_rd))
			data_q <= shifter;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid   <= 1'b0;
			overrun <= 1'b0;
		end else begin
			if (byte_done && (!valid || data_rd))
				valid <= 1'b1;
			else if (data_rd)
				valid <= 1'b0;

			// Sticky until status read, a new overrun wins
			if (byte_done && valid && !data_rd)
				overrun <= 1'b1;
			else if (stat_rd)
				overrun <= 1'b0;
		end
	end

	assign irq = valid;

	// ------------------------------
	// APB register access

	assign access  = bus.psel && bus.penable;
	assign op      = apb_pkg::apb_op_e'(bus.pwrite);
	assign offset  = uart_pkg::uart_reg_e'(bus.paddr[2:0]);
	assign in_page = (bus.paddr[7:3] == '0);

	always_comb begin
		rdata = '0;
		err   = 1'b0;
		if (!in_page) begin
			err = 1'b1;
		end else begin
			case (offset)
				uart_pkg::REG_DATA: begin
					// Read only, and empty reads are refused
					err        = (op == apb_pkg::OP_WRITE) || !valid;
					rdata[7:0] = data_q;
				end
				uart_pkg::REG_STATUS: begin
					err        = (op == apb_pkg::OP_WRITE);
					rdata[1:0] = {overrun, valid};
				end
				default:
					err = 1'b1;
			endcase
		end
	end

	assign data_rd = access && !err && (op == apb_pkg::OP_READ) &&
		(offset == uart_pkg::REG_DATA);
	assign stat_rd = access && !err && (op == apb_pkg::OP_READ) &&
		(offset == uart_pkg::REG_STATUS);

	// Zero wait states
	assign bus.pready  = access;
	assign bus.pslverr = access && err;
	assign bus.prdata  = access ? rdata : '0;

	// Overrun only ever rises on top of a held byte
	a_overrun_valid: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(overrun) |-> $past(valid) && valid);

endmodule

// ==== source/uart_tx_unit.sv ====
`include "periph_cfg.svh"

module uart_tx_unit (
	input  logic     clk,
	input  logic     arst_n,
	apb_if.completer bus,
	output logic     tx
);

	localparam int DIV_W = $clog2(`PERIPH_CLKDIV);

	uart_pkg::tx_state_e       state;
	uart_pkg::uart_reg_e       offset;
	apb_pkg::apb_op_e          op;
	logic                      access;
	logic                      in_page;
	logic                      busy;
	logic                      err;
	logic                      load;
	logic [`PERIPH_DATA_W-1:0] rdata;
	logic [DIV_W-1:0]          div_cnt;
	logic                      bit_end;
	logic [2:0]                bit_idx;
	logic [7:0]                shifter;

	// ------------------------------
	// APB register access

	assign access  = bus.psel && bus.penable;
	assign op      = apb_pkg::apb_op_e'(bus.pwrite);
	assign offset  = uart_pkg::uart_reg_e'(bus.paddr[2:0]);
	// Only the first eight bytes of the page are decoded
	assign in_page = (bus.paddr[7:3] == '0);
	assign busy    = (state != uart_pkg::TX_IDLE);

	always_comb begin
		rdata = '0;
		err   = 1'b0;
		if (!in_page) begin
			err = 1'b1;
		end else begin
			case (offset)
				// Write only, and refused while a frame is on the line
				uart_pkg::REG_DATA:
					err = (op == apb_pkg::OP_READ) || busy;
				uart_pkg::REG_STATUS: begin
					err      = (op == apb_pkg::OP_WRITE);
					rdata[0] = busy;
				end
				default:
					err = 1'b1;
			endcase
		end
	end

	// Zero wait states
	assign bus.pready  = access;
	assign bus.pslverr = access && err;
	assign bus.prdata  = access ? rdata : '0;

	// DATA is the only writable register
	assign load = access && !err && (op == apb_pkg::OP_WRITE);

	// ------------------------------
	// Bit timing

	assign bit_end = (div_cnt == DIV_W'(`PERIPH_CLKDIV - 1));

	// ------------------------------
	// Frame FSM

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= uart_pkg::TX_IDLE;
			div_cnt <= '0;
			bit_idx <= '0;
			tx      <= 1'b1;
		end else begin
			// Counter free runs through a frame
			if (state == uart_pkg::TX_IDLE)
				div_cnt <= '0;
			else
				div_cnt <= bit_end ? '0 : div_cnt + 1'b1;

			case (state)
				uart_pkg::TX_IDLE: begin
					// Start bit goes out on the edge after the write
					if (load) begin
						state <= uart_pkg::TX_START;
						tx    <= 1'b0;
					end
				end
				uart_pkg::TX_START: begin
					if (bit_end) begin
						state   <= uart_pkg::TX_DATA;
						bit_idx <= '0;
						tx      <= shifter[0];
					end
				end
				uart_pkg::TX_DATA: begin
					if (bit_end) begin
						if (bit_idx == 3'd7) begin
							state <= uart_pkg::TX_STOP;
							tx    <= 1'b1;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							// Next bit, shifter moves on the same edge
							tx      <= shifter[1];
						end
					end
				end
				default: begin
					// Stop bit, busy drops when it ends
					if (bit_end)
						state <= uart_pkg::TX_IDLE;
				end
			endcase
		end
	end

	// LSB first shift register
	always_ff @(posedge clk) begin
		if (load)
			shifter <= bus.pwdata[7:0];
		else if (state == uart_pkg::TX_DATA && bit_end)
			shifter <= shifter >> 1;
	end

	// Line idles high between frames
	a_idle_high: assert property (@(posedge clk) disable iff (!arst_n)
		(state == uart_pkg::TX_IDLE) |-> tx);

endmodule

// ==== source/apb_decode_mux.sv ====
`include "periph_cfg.svh"

module apb_decode_mux (
	input  logic                      clk,
	input  logic                      arst_n,

	// Upstream APB
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [`PERIPH_ADDR_W-1:0] paddr,
	input  logic [`PERIPH_DATA_W-1:0] pwdata,
	output logic [`PERIPH_DATA_W-1:0] prdata,
	output logic                      pready,
	output logic                      pslverr,

	// Downstream unit buses
	apb_if.requester                  tx_bus,
	apb_if.requester                  rx_bus
);

	apb_pkg::apb_region_e      region;
	apb_pkg::apb_op_e          op;
	logic [`PERIPH_ADDR_W-1:0] page;

	// ------------------------------
	// Region decode

	// Only the upper address bits pick the unit
	assign page = paddr & `PERIPH_REGION_MASK;

	always_comb begin
		if (page == `PERIPH_TX_BASE)
			region = apb_pkg::REGION_TX;
		else if (page == `PERIPH_RX_BASE)
			region = apb_pkg::REGION_RX;
		else
			region = apb_pkg::REGION_NONE;
	end

	assign op = pwrite ? apb_pkg::OP_WRITE : apb_pkg::OP_READ;

	// ------------------------------
	// Request routing

	// psel goes to the matching unit only
	assign tx_bus.psel    = psel && (page == `PERIPH_TX_BASE);
	assign rx_bus.psel    = psel && (page == `PERIPH_RX_BASE);

	// Everything else is broadcast
	assign tx_bus.penable = penable;
	assign tx_bus.pwrite  = (op == apb_pkg::OP_WRITE);
	assign tx_bus.paddr   = paddr;
	assign tx_bus.pwdata  = pwdata;

	assign rx_bus.penable = penable;
	assign rx_bus.pwrite  = (op == apb_pkg::OP_WRITE);
	assign rx_bus.paddr   = paddr;
	assign rx_bus.pwdata  = pwdata;

	// ------------------------------
	// Response merge

	always_comb begin
		case (region)
			apb_pkg::REGION_TX: begin
				prdata  = tx_bus.prdata;
				pready  = tx_bus.pready;
				pslverr = tx_bus.pslverr;
			end
			apb_pkg::REGION_RX: begin
				prdata  = rx_bus.prdata;
				pready  = rx_bus.pready;
				pslverr = rx_bus.pslverr;
			end
			default: begin
				// Unmapped, complete in the first access cycle with an error
				prdata  = '0;
				pready  = psel && penable;
				pslverr = psel && penable;
			end
		endcase
	end

	// ------------------------------
	// Bus checks

	// Unit selects are one-hot or idle, region pages must not overlap
	a_one_unit_sel: assert property (@(posedge clk) disable iff (!arst_n)
		!(tx_bus.psel && rx_bus.psel));

	// Requester protocol, no access phase outside a transfer
	a_penable_psel: assert property (@(posedge clk) disable iff (!arst_n)
		penable |-> psel);

endmodule

// ==== source/apb_if.sv ====
`include "periph_cfg.svh"

interface apb_if;

	// Request side
	logic                      psel;
	logic                      penable;
	logic                      pwrite;
	logic [`PERIPH_ADDR_W-1:0] paddr;
	logic [`PERIPH_DATA_W-1:0] pwdata;

	// Response side, valid in the cycle pready is high
	logic [`PERIPH_DATA_W-1:0] prdata;
	logic                      pready;
	logic                      pslverr;

	// Decoder side
	modport requester (
		output psel, penable, pwrite, paddr, pwdata,
		input  prdata, pready, pslverr
	);

	// Unit side
	modport completer (
		input  psel, penable, pwrite, paddr, pwdata,
		output prdata, pready, pslverr
	);

endinterface

// ==== source/uart_pkg.sv ====
package uart_pkg;

	// ------------------------------
	// Register map

	// Byte offsets inside a unit page
	// Same layout for tx and rx units
	typedef enum logic [2:0] {
		REG_DATA   = 3'h0,
		REG_STATUS = 3'h4
	} uart_reg_e;

	// ------------------------------
	// Serial state machines

	// Transmitter, one state per frame section
	typedef enum logic [1:0] {
		TX_IDLE  = 2'd0,
		TX_START = 2'd1,
		TX_DATA  = 2'd2,
		TX_STOP  = 2'd3
	} tx_state_e;

	// Receiver, START covers the half bit up to the start check
	typedef enum logic [1:0] {
		RX_IDLE  = 2'd0,
		RX_START = 2'd1,
		RX_DATA  = 2'd2,
		RX_STOP  = 2'd3
	} rx_state_e;

endpackage

// ==== source/apb_pkg.sv ====
package apb_pkg;

	// ------------------------------
	// Decode targets

	// Which completer owns the current address
	// REGION_NONE is answered by the decoder itself
	typedef enum logic [1:0] {
		REGION_TX   = 2'd0,
		REGION_RX   = 2'd1,
		REGION_NONE = 2'd2
	} apb_region_e;

	// ------------------------------
	// Access opcodes

	// Direction of a transfer, same encoding as pwrite
	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} apb_op_e;

endpackage

// ==== include/periph_cfg.svh ====
`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

// ------------------------------
// Peripheral subsystem constants

// Clock cycles per UART bit
`define PERIPH_CLKDIV 8

// APB bus widths
`define PERIPH_ADDR_W 12
`define PERIPH_DATA_W 32

// Region map, one 256 byte page per unit
`define PERIPH_TX_BASE     12'h000
`define PERIPH_RX_BASE     12'h100
`define PERIPH_REGION_MASK 12'hf00

`endif
